/* serv_settings.svh */
`ifndef SERV_SETTINGS_SVH
`define SERV_SETTINGS_SVH

// Datapath and register file geometry
`define SERV_XLEN       32
`define SERV_REG_AW     5
`define SERV_RESET_PC   32'h0000_0000

// Major opcodes
`define SERV_OPC_OP     7'b0110011
`define SERV_OPC_OP_IMM 7'b0010011
`define SERV_OPC_LUI    7'b0110111

// funct3 codes shared by OP and OP-IMM
`define SERV_F3_ADD     3'b000
`define SERV_F3_XOR     3'b100
`define SERV_F3_OR      3'b110
`define SERV_F3_AND     3'b111

`endif

/* serv_pkg.sv */
`include "serv_settings.svh"

package serv_pkg;

   // One instruction word, read through the R, I or U format
   typedef union packed {
      struct packed {
         logic [6:0]              funct7;
         logic [`SERV_REG_AW-1:0] rs2;
         logic [`SERV_REG_AW-1:0] rs1;
         logic [2:0]              funct3;
         logic [`SERV_REG_AW-1:0] rd;
         logic [6:0]              opcode;
      } r_view;
      struct packed {
         logic [11:0]             imm;
         logic [`SERV_REG_AW-1:0] rs1;
         logic [2:0]              funct3;
         logic [`SERV_REG_AW-1:0] rd;
         logic [6:0]              opcode;
      } i_view;
      struct packed {
         logic [19:0]             imm;
         logic [`SERV_REG_AW-1:0] rd;
         logic [6:0]              opcode;
      } u_view;
   } insn_t;

   typedef enum logic [1:0] {
      ALU_ADD = 2'd0,
      ALU_XOR = 2'd1,
      ALU_OR  = 2'd2,
      ALU_AND = 2'd3
   } alu_op_e;

   typedef struct packed {
      alu_op_e    alu_op;
      logic       sub;
      logic       use_imm;
      logic       lui;
      logic       rd_en;
      // One-hot pick of the imm, bool or sum result
      logic [2:0] rd_sel;
   } ctrl_t;

   typedef struct packed {
      logic       en;
      logic [4:0] idx;
      logic       done;
   } cnt_t;

   typedef struct packed {
      logic                  cyc;
      logic [`SERV_XLEN-1:0] adr;
   } ibus_req_t;

   typedef struct packed {
      logic                  ack;
      logic [`SERV_XLEN-1:0] rdt;
   } ibus_rsp_t;

   typedef struct packed {
      logic                    rreq;
      logic [`SERV_REG_AW-1:0] rreg0;
      logic [`SERV_REG_AW-1:0] rreg1;
      logic [`SERV_REG_AW-1:0] wreg0;
      logic                    wen0;
      logic                    wdata0;
   } rf_req_t;

   typedef struct packed {
      logic ready;
      logic rdata0;
      logic rdata1;
   } rf_rsp_t;

endpackage

/* serv_state.sv */
`timescale 1ns/10ps
`default_nettype none

module serv_state (
   input  wire                  clk,
   input  wire                  i_rst_n,
   input  wire                  i_ibus_ack,
   input  wire                  i_rf_ready,
   output logic                 o_ibus_cyc,
   output logic                 o_rf_rreq,
   output serv_pkg::cnt_t       o_cnt
);

   localparam logic [1:0] ST_FETCH = 2'd0;
   localparam logic [1:0] ST_REQ   = 2'd1;
   localparam logic [1:0] ST_WAIT  = 2'd2;
   localparam logic [1:0] ST_EXEC  = 2'd3;

   logic [1:0] state;
   logic [4:0] idx;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= ST_FETCH;
         idx   <= 5'd0;
      end else begin
         case (state)
            ST_FETCH: begin
               if (i_ibus_ack) begin
                  state <= ST_REQ;
               end
            end
            ST_REQ: begin
               state <= ST_WAIT;
            end
            ST_WAIT: begin
               // Bit 0 comes out of the RF in the cycle after ready
               if (i_rf_ready) begin
                  state <= ST_EXEC;
                  idx   <= 5'd0;
               end
            end
            default: begin
               idx <= idx + 5'd1;
               if (idx == 5'd31) begin
                  state <= ST_FETCH;
               end
            end
         endcase
      end
   end

   assign o_ibus_cyc = (state == ST_FETCH);
   assign o_rf_rreq  = (state == ST_REQ);

   assign o_cnt.en   = (state == ST_EXEC);
   assign o_cnt.idx  = idx;
   assign o_cnt.done = (state == ST_EXEC) && (idx == 5'd31);

endmodule
`default_nettype wire

/* serv_decode.sv */
`timescale 1ns/10ps
`default_nettype none
`include "serv_settings.svh"

module serv_decode (
   input  wire                      clk,
   input  wire                      i_rst_n,
   input  serv_pkg::ibus_rsp_t      i_ibus,
   input  serv_pkg::cnt_t           i_cnt,
   output serv_pkg::ctrl_t          o_ctrl,
   output logic                     o_imm,
   output logic [`SERV_REG_AW-1:0]  o_rreg0,
   output logic [`SERV_REG_AW-1:0]  o_rreg1,
   output logic [`SERV_REG_AW-1:0]  o_wreg0,
   output logic                     o_wen0
);

   serv_pkg::insn_t      insn;
   serv_pkg::ctrl_t      ctrl_d;
   logic                 f3_ok;
   logic                 is_op;
   logic                 is_op_imm;
   logic                 is_lui;
   logic [`SERV_XLEN-1:0] imm_d;
   logic [`SERV_XLEN-1:0] imm_q;

   assign insn = i_ibus.rdt;

   always_comb begin
      f3_ok = (insn.r_view.funct3 == `SERV_F3_ADD) ||
              (insn.r_view.funct3 == `SERV_F3_XOR) ||
              (insn.r_view.funct3 == `SERV_F3_OR)  ||
              (insn.r_view.funct3 == `SERV_F3_AND);

      // SUB is the only R-type with funct7 bit 5 set
      is_op = (insn.r_view.opcode == `SERV_OPC_OP) && f3_ok &&
              ((insn.r_view.funct7 == 7'b0000000) ||
               ((insn.r_view.funct7 == 7'b0100000) &&
                (insn.r_view.funct3 == `SERV_F3_ADD)));
      is_op_imm = (insn.r_view.opcode == `SERV_OPC_OP_IMM) && f3_ok;
      is_lui    = (insn.r_view.opcode == `SERV_OPC_LUI);

      case (insn.r_view.funct3)
         `SERV_F3_XOR: ctrl_d.alu_op = serv_pkg::ALU_XOR;
         `SERV_F3_OR:  ctrl_d.alu_op = serv_pkg::ALU_OR;
         `SERV_F3_AND: ctrl_d.alu_op = serv_pkg::ALU_AND;
         default:      ctrl_d.alu_op = serv_pkg::ALU_ADD;
      endcase

      ctrl_d.sub     = is_op && insn.r_view.funct7[5];
      ctrl_d.use_imm = !is_op;
      ctrl_d.lui     = is_lui;
      ctrl_d.rd_en   = (is_op || is_op_imm || is_lui) && (insn.r_view.rd != '0);

      if (is_lui) begin
         ctrl_d.rd_sel = 3'b100;
      end else if (ctrl_d.alu_op == serv_pkg::ALU_ADD) begin
         ctrl_d.rd_sel = 3'b001;
      end else begin
         ctrl_d.rd_sel = 3'b010;
      end

      if (is_lui) begin
         imm_d = {insn.u_view.imm, 12'b0};
      end else begin
         imm_d = {{(`SERV_XLEN-12){insn.i_view.imm[11]}}, insn.i_view.imm};
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_ctrl <= '0;
      end else if (i_ibus.ack) begin
         o_ctrl <= ctrl_d;
      end
   end

   always_ff @(posedge clk) begin
      if (i_ibus.ack) begin
         o_rreg0 <= insn.r_view.rs1;
         o_rreg1 <= insn.r_view.rs2;
         o_wreg0 <= insn.r_view.rd;
         imm_q   <= imm_d;
      end else if (i_cnt.en) begin
         imm_q <= {1'b0, imm_q[`SERV_XLEN-1:1]};
      end
   end

   assign o_imm  = imm_q[0];
   assign o_wen0 = o_ctrl.rd_en && i_cnt.en;

endmodule
`default_nettype wire

/* serv_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module serv_alu (
   input  wire                clk,
   input  wire                i_rst_n,
   input  serv_pkg::cnt_t     i_cnt,
   input  serv_pkg::ctrl_t    i_ctrl,
   input  wire                i_rs1,
   input  wire                i_rs2,
   input  wire                i_imm,
   output logic               o_rd
);

   logic op_a;
   logic op_b;
   logic carry_in;
   logic carry_q;
   logic sum;
   logic bool_rd;

   // rs1 field holds immediate bits on LUI
   assign op_a = i_rs1 && !i_ctrl.lui;
   assign op_b = (i_ctrl.use_imm ? i_imm : i_rs2) ^ i_ctrl.sub;

   // Carry-in of one turns the inverted operand into two's complement
   assign carry_in = (i_cnt.idx == 5'd0) ? i_ctrl.sub : carry_q;
   assign sum      = op_a ^ op_b ^ carry_in;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
      end else if (i_cnt.en) begin
         carry_q <= (op_a & op_b) | (carry_in & (op_a ^ op_b));
      end
   end

   always_comb begin
      case (i_ctrl.alu_op)
         serv_pkg::ALU_OR:  bool_rd = op_a | op_b;
         serv_pkg::ALU_AND: bool_rd = op_a & op_b;
         default:           bool_rd = op_a ^ op_b;
      endcase
   end

   assign o_rd = |(i_ctrl.rd_sel & {i_imm, bool_rd, sum});

endmodule
`default_nettype wire

/* serv_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none
`include "serv_settings.svh"

module serv_ctrl (
   input  wire                     clk,
   input  wire                     i_rst_n,
   input  serv_pkg::cnt_t          i_cnt,
   output logic [`SERV_XLEN-1:0]   o_pc
);

   logic [`SERV_XLEN-1:0] pc;
   logic                  add_bit;
   logic                  carry_in;
   logic                  carry_q;
   logic                  new_bit;

   // Serial +4 means adding a one at bit 2
   assign add_bit  = (i_cnt.idx == 5'd2);
   assign carry_in = (i_cnt.idx == 5'd0) ? 1'b0 : carry_q;
   assign new_bit  = pc[0] ^ add_bit ^ carry_in;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc      <= `SERV_RESET_PC;
         carry_q <= 1'b0;
      end else if (i_cnt.en) begin
         pc      <= {new_bit, pc[`SERV_XLEN-1:1]};
         carry_q <= (pc[0] & add_bit) | (carry_in & (pc[0] ^ add_bit));
      end
   end

   assign o_pc = pc;

endmodule
`default_nettype wire

/* serv_top.sv */
`timescale 1ns/10ps
`default_nettype none

module serv_top (
   input  wire                    clk,
   input  wire                    i_rst_n,
   input  serv_pkg::ibus_rsp_t    i_ibus,
   output serv_pkg::ibus_req_t    o_ibus,
   input  serv_pkg::rf_rsp_t      i_rf,
   output serv_pkg::rf_req_t      o_rf
);

   serv_pkg::cnt_t  cnt;
   serv_pkg::ctrl_t ctrl;
   logic            ibus_cyc;
   logic            rf_rreq;
   logic [31:0]     pc;
   logic            imm;
   logic [4:0]      rreg0;
   logic [4:0]      rreg1;
   logic [4:0]      wreg0;
   logic            wen0;
   logic            alu_rd;

   serv_state state (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus.ack),
      .i_rf_ready (i_rf.ready),
      .o_ibus_cyc (ibus_cyc),
      .o_rf_rreq  (rf_rreq),
      .o_cnt      (cnt)
   );

   serv_decode decode (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_ibus  (i_ibus),
      .i_cnt   (cnt),
      .o_ctrl  (ctrl),
      .o_imm   (imm),
      .o_rreg0 (rreg0),
      .o_rreg1 (rreg1),
      .o_wreg0 (wreg0),
      .o_wen0  (wen0)
   );

   serv_alu alu (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_cnt   (cnt),
      .i_ctrl  (ctrl),
      .i_rs1   (i_rf.rdata0),
      .i_rs2   (i_rf.rdata1),
      .i_imm   (imm),
      .o_rd    (alu_rd)
   );

   serv_ctrl ctrl_pc (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_cnt   (cnt),
      .o_pc    (pc)
   );

   assign o_ibus = '{cyc: ibus_cyc, adr: pc};

   assign o_rf = '{rreq:   rf_rreq,
                   rreg0:  rreg0,
                   rreg1:  rreg1,
                   wreg0:  wreg0,
                   wen0:   wen0,
                   wdata0: alu_rd};

endmodule
`default_nettype wire

/* tb_serv_top.sv */
`timescale 1ns/10ps
`include "serv_settings.svh"

module tb_serv_top;

   localparam int CLK_PERIOD   = 40;
   localparam int N_INSN       = 200;
   localparam int CYC_PER_INSN = 45;

   // R-type kinds first, then I-type, then LUI
   typedef enum int {K_ADD, K_SUB, K_XOR, K_OR, K_AND,
                     K_ADDI, K_XORI, K_ORI, K_ANDI, K_LUI, K_BAD} kind_e;

   logic                clk;
   logic                rst_n;
   serv_pkg::ibus_rsp_t ibus_rsp;
   serv_pkg::ibus_req_t ibus_req;
   serv_pkg::rf_rsp_t   rf_rsp;
   serv_pkg::rf_req_t   rf_req;
   logic [31:0]         regs [0:31];
   logic [31:0]         exp_pc;

   serv_top i_serv_top (
      .clk     (clk),
      .i_rst_n (rst_n),
      .i_ibus  (ibus_rsp),
      .o_ibus  (ibus_req),
      .i_rf    (rf_rsp),
      .o_rf    (rf_req)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(N_INSN * CYC_PER_INSN * CLK_PERIOD * 2);
      $display("Watchdog expired: the core stopped completing instructions in time");
      $display("Finished with errors");
      $fatal(1, "Timeout");
   end

   task automatic check_equal(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp)
      else begin
         $display("FAILED at %0d ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
         $display("Finished with errors");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task automatic make_insn(output logic [31:0] word, output kind_e kind);
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [11:0] imm12;
      rd    = ($urandom % 8 == 0) ? 5'd0 : 5'($urandom);
      rs1   = 5'($urandom);
      rs2   = 5'($urandom);
      imm12 = 12'($urandom);
      if ($urandom % 10 == 0) begin
         kind = K_BAD;
         word = $urandom;
         case ($urandom % 3)
            0: begin
               // Shift and compare funct3 codes under OP or OP-IMM
               word[6:0] = word[30] ? `SERV_OPC_OP : `SERV_OPC_OP_IMM;
               while (word[14:12] == `SERV_F3_ADD || word[14:12] == `SERV_F3_XOR ||
                      word[14:12] == `SERV_F3_OR || word[14:12] == `SERV_F3_AND) begin
                  word[14:12] = 3'($urandom);
               end
            end
            1: begin
               // OP word whose funct7 fits no kept operation
               word[6:0] = `SERV_OPC_OP;
               if (word[25]) begin
                  word[31:25] = 7'b0100000;
               end
               while (word[31:25] == 7'b0000000 ||
                      (word[31:25] == 7'b0100000 && word[14:12] == `SERV_F3_ADD)) begin
                  if (word[31:25] == 7'b0000000) begin
                     word[31:25] = 7'($urandom);
                  end else begin
                     word[14:12] = 3'($urandom);
                  end
               end
            end
            default: begin
               // Steer clear of the decoded major opcodes
               while (word[6:0] == `SERV_OPC_OP || word[6:0] == `SERV_OPC_OP_IMM ||
                      word[6:0] == `SERV_OPC_LUI) begin
                  word[6:0] = 7'($urandom);
               end
            end
         endcase
      end else begin
         kind = kind_e'($urandom % 10);
         case (kind)
            K_ADD:   word = {7'b0000000, rs2, rs1, `SERV_F3_ADD, rd, `SERV_OPC_OP};
            K_SUB:   word = {7'b0100000, rs2, rs1, `SERV_F3_ADD, rd, `SERV_OPC_OP};
            K_XOR:   word = {7'b0000000, rs2, rs1, `SERV_F3_XOR, rd, `SERV_OPC_OP};
            K_OR:    word = {7'b0000000, rs2, rs1, `SERV_F3_OR, rd, `SERV_OPC_OP};
            K_AND:   word = {7'b0000000, rs2, rs1, `SERV_F3_AND, rd, `SERV_OPC_OP};
            K_ADDI:  word = {imm12, rs1, `SERV_F3_ADD, rd, `SERV_OPC_OP_IMM};
            K_XORI:  word = {imm12, rs1, `SERV_F3_XOR, rd, `SERV_OPC_OP_IMM};
            K_ORI:   word = {imm12, rs1, `SERV_F3_OR, rd, `SERV_OPC_OP_IMM};
            K_ANDI:  word = {imm12, rs1, `SERV_F3_AND, rd, `SERV_OPC_OP_IMM};
            default: word = {20'($urandom), rd, `SERV_OPC_LUI};
         endcase
      end
   endtask

   function automatic logic [31:0] model_result(input logic [31:0] word, input kind_e kind);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      a   = regs[word[19:15]];
      b   = regs[word[24:20]];
      imm = {{20{word[31]}}, word[31:20]};
      case (kind)
         K_ADD:   return a + b;
         K_SUB:   return a - b;
         K_XOR:   return a ^ b;
         K_OR:    return a | b;
         K_AND:   return a & b;
         K_ADDI:  return a + imm;
         K_XORI:  return a ^ imm;
         K_ORI:   return a | imm;
         K_ANDI:  return a & imm;
         K_LUI:   return {word[31:12], 12'h000};
         default: return 32'h0;
      endcase
   endfunction

   // Random ack delay with garbage on rdt before the ack cycle
   task automatic fetch(input logic [31:0] word);
      int delay;
      int i;
      delay = $urandom % 4;
      for (i = 0; i <= delay; i++) begin
         ibus_rsp.ack = (i == delay);
         ibus_rsp.rdt = (i == delay) ? word : $urandom;
         @(posedge clk);
         check_equal("o_ibus.cyc", 1, 32'(ibus_req.cyc));
         check_equal("o_ibus.adr", exp_pc, ibus_req.adr);
         check_equal("o_rf.rreq", 0, 32'(rf_req.rreq));
         check_equal("o_rf.wen0", 0, 32'(rf_req.wen0));
         @(negedge clk);
      end
      ibus_rsp.ack = 1'b0;
      ibus_rsp.rdt = $urandom;
      @(posedge clk);
      check_equal("o_ibus.cyc", 0, 32'(ibus_req.cyc));
      check_equal("o_rf.rreq", 1, 32'(rf_req.rreq));
      @(negedge clk);
   endtask

   task automatic answer_ready();
      int delay;
      int i;
      delay = 1 + $urandom % 3;
      for (i = 0; i < delay; i++) begin
         rf_rsp.ready = (i == delay - 1);
         @(posedge clk);
         check_equal("o_ibus.cyc", 0, 32'(ibus_req.cyc));
         check_equal("o_rf.rreq", 0, 32'(rf_req.rreq));
         check_equal("o_rf.wen0", 0, 32'(rf_req.wen0));
         @(negedge clk);
      end
      rf_rsp.ready = 1'b0;
   endtask

   // Serial RF reads see old values until rd is written after the last bit
   task automatic execute(input logic [31:0] word, input kind_e kind);
      logic [31:0] result;
      logic        wen;
      int          k;
      result = model_result(word, kind);
      wen    = (kind != K_BAD) && (word[11:7] != 5'd0);
      for (k = 0; k < 32; k++) begin
         rf_rsp.rdata0 = regs[rf_req.rreg0][k];
         rf_rsp.rdata1 = regs[rf_req.rreg1][k];
         @(posedge clk);
         check_equal("o_ibus.cyc", 0, 32'(ibus_req.cyc));
         check_equal("o_rf.wen0", 32'(wen), 32'(rf_req.wen0));
         if (kind < K_LUI) begin
            check_equal("o_rf.rreg0", 32'(word[19:15]), 32'(rf_req.rreg0));
         end
         if (kind <= K_AND) begin
            check_equal("o_rf.rreg1", 32'(word[24:20]), 32'(rf_req.rreg1));
         end
         if (wen) begin
            check_equal("o_rf.wreg0", 32'(word[11:7]), 32'(rf_req.wreg0));
            check_equal($sformatf("o_rf.wdata0[%0d]", k), 32'(result[k]),
                        32'(rf_req.wdata0));
         end
         @(negedge clk);
      end
      if (wen) begin
         regs[word[11:7]] = result;
      end
   endtask

   initial begin
      logic [31:0] word;
      kind_e       kind;
      int          n;
      void'($urandom(32'h8076_ffce));
      rst_n    = 1'b0;
      ibus_rsp = '0;
      rf_rsp   = '0;
      for (n = 0; n < 32; n++) begin
         regs[n] = (n == 0) ? 32'h0 : $urandom;
      end
      exp_pc = `SERV_RESET_PC;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (n = 0; n < N_INSN; n++) begin
         make_insn(word, kind);
         fetch(word);
         answer_ready();
         execute(word, kind);
         exp_pc = exp_pc + 32'd4;
      end
      $display("Finished with no errors");
      $finish;
   end

endmodule

/* filelist.f */
+incdir+.
serv_pkg.sv
serv_state.sv
serv_decode.sv
serv_alu.sv
serv_ctrl.sv
serv_top.sv
tb_serv_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/10ps
TOP       := tb_serv_top
FILELIST  := filelist.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Finished with no errors

SOURCES := $(filter %.sv,$(shell cat $(FILELIST))) serv_settings.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
